//--- Bender.yml
package:
  name: pixel_generator

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pg_pkg.sv
      - rtl/pg_regfile.sv
      - rtl/pixel_scan.sv
      - rtl/shade_lane.sv
      - rtl/pixel_packer.sv
      - rtl/pixel_generator.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/pixel_generator_props.sv
      - bench/tb_pixel_generator.sv

//--- bench/pixel_generator_props.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_generator_props (
    input wire        out_stream_aclk,
    input wire        axi_resetn,
    input wire [31:0] out_stream_tdata,
    input wire        out_stream_tlast,
    input wire        out_stream_tuser,
    input wire        out_stream_tvalid,
    input wire        out_stream_tready,
    input wire [1:0]  s_axi_lite_bresp,
    input wire        s_axi_lite_bvalid,
    input wire        s_axi_lite_bready,
    input wire [31:0] s_axi_lite_rdata,
    input wire [1:0]  s_axi_lite_rresp,
    input wire        s_axi_lite_rvalid,
    input wire        s_axi_lite_rready
);

    beat_held: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        out_stream_tvalid && !out_stream_tready |=> out_stream_tvalid &&
            $stable({out_stream_tdata, out_stream_tuser, out_stream_tlast}))
        else $error("stream beat changed while stalled");

    bresp_held: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        s_axi_lite_bvalid && !s_axi_lite_bready |=> s_axi_lite_bvalid &&
            $stable(s_axi_lite_bresp))
        else $error("write response dropped before bready");

    rdata_held: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        s_axi_lite_rvalid && !s_axi_lite_rready |=> s_axi_lite_rvalid &&
            $stable({s_axi_lite_rdata, s_axi_lite_rresp}))
        else $error("read data changed before rready");

endmodule

`default_nettype wire

//--- bench/tb_pixel_generator.sv
`timescale 1ns/10ps
`default_nettype none

`include "pg_macros.svh"

module tb_pixel_generator;

    localparam int BEATS_PER_LINE = `PG_WIDTH * 24 / 32;
    localparam int FRAME_BEATS    = BEATS_PER_LINE * `PG_HEIGHT;
    localparam int NUM_FRAMES     = 5;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_BEATS * 8 + 1000;
    localparam logic [31:0] REG_VALS [5] = '{32'h5a5a_c3c2, 32'hdead_0102, 32'h0000_beef,
                                             32'h00c0_ffee, 32'h0012_3456};

    logic        out_stream_aclk;
    logic        axi_resetn;
    logic [31:0] tdata;
    logic [3:0]  tkeep;
    logic        tlast;
    logic        tready;
    logic        tvalid;
    logic        tuser;
    logic [7:0]  araddr;
    logic        arready;
    logic        arvalid;
    logic [7:0]  awaddr;
    logic        awready;
    logic        awvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic [31:0] rdata;
    logic        rready;
    logic [1:0]  rresp;
    logic        rvalid;
    logic [31:0] wdata;
    logic        wready;
    logic        wvalid;

    int          errors;
    int          checks;
    int          cycles;
    int          beat_idx;
    int          frames_done;
    logic        stopped;
    logic        random_ready;
    logic [31:0] lfsr_state;
    logic [31:0] first_frame [FRAME_BEATS];
    int          exp_cx;     // config as written by the testbench
    int          exp_cy;
    int          exp_r2;
    logic [23:0] exp_obj;
    logic [23:0] exp_bg;

    pixel_generator uut (
        .out_stream_aclk    (out_stream_aclk),
        .axi_resetn         (axi_resetn),
        .out_stream_tdata   (tdata),
        .out_stream_tkeep   (tkeep),
        .out_stream_tlast   (tlast),
        .out_stream_tready  (tready),
        .out_stream_tvalid  (tvalid),
        .out_stream_tuser   (tuser),
        .s_axi_lite_araddr  (araddr),
        .s_axi_lite_arready (arready),
        .s_axi_lite_arvalid (arvalid),
        .s_axi_lite_awaddr  (awaddr),
        .s_axi_lite_awready (awready),
        .s_axi_lite_awvalid (awvalid),
        .s_axi_lite_bready  (bready),
        .s_axi_lite_bresp   (bresp),
        .s_axi_lite_bvalid  (bvalid),
        .s_axi_lite_rdata   (rdata),
        .s_axi_lite_rready  (rready),
        .s_axi_lite_rresp   (rresp),
        .s_axi_lite_rvalid  (rvalid),
        .s_axi_lite_wdata   (wdata),
        .s_axi_lite_wready  (wready),
        .s_axi_lite_wvalid  (wvalid)
    );

    bind pixel_generator pixel_generator_props u_props (.*);

    always #5 out_stream_aclk = ~out_stream_aclk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // disc shade rule, channels darken by the shifted distance and clamp at zero
    function automatic logic [23:0] ref_pixel(input int x, input int y);
        int          dx;
        int          dy;
        int          d;
        int          f;
        int          ch_val;
        logic [23:0] c;
        dx = x - exp_cx;
        dy = y - exp_cy;
        d  = dx * dx + dy * dy;
        if (d >= exp_r2) return exp_bg;
        f = d >> `PG_FALLOFF_SHIFT;
        for (int ch = 0; ch < 3; ch++) begin
            ch_val = int'(exp_obj[ch*8 +: 8]);
            c[ch*8 +: 8] = (ch_val > f) ? 8'(ch_val - f) : 8'd0;
        end
        return c;
    endfunction

    function automatic logic [31:0] expected_word(input int idx);
        int          line;
        int          grp;
        int          k;
        logic [95:0] grp_bits;
        line = idx / BEATS_PER_LINE;
        grp  = (idx % BEATS_PER_LINE) / 3;
        k    = idx % 3;
        for (int i = 0; i < 4; i++) begin
            grp_bits[i*24 +: 24] = ref_pixel(grp * 4 + i, line); // pixel 0 lowest
        end
        return grp_bits[k*32 +: 32];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        logic aw_done;
        logic w_done;
        @(negedge out_stream_aclk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        aw_done = 1'b0;
        w_done  = 1'b0;
        while (!(aw_done && w_done)) begin
            if (awvalid && awready) aw_done = 1'b1; // taken at next rising edge
            if (wvalid && wready) w_done = 1'b1;
            @(negedge out_stream_aclk);
            if (aw_done) awvalid = 1'b0;
            if (w_done) wvalid = 1'b0;
        end
        while (!bvalid) @(negedge out_stream_aclk);
        @(negedge out_stream_aclk); // response stalled one cycle
        resp   = bresp;
        bready = 1'b1;
        @(negedge out_stream_aclk);
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge out_stream_aclk);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge out_stream_aclk);
        @(negedge out_stream_aclk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge out_stream_aclk);
        @(negedge out_stream_aclk); // read data stalled one cycle
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge out_stream_aclk);
        rready = 1'b0;
    endtask

    task automatic configure_disc(input int cx, input int cy, input int r2,
                                  input logic [23:0] obj, input logic [23:0] bg);
        logic [1:0] resp;
        exp_cx  = cx;
        exp_cy  = cy;
        exp_r2  = r2;
        exp_obj = obj;
        exp_bg  = bg;
        write_reg(8'h04, {16'h0, 8'(cy), 8'(cx)}, resp);
        check_value("cfg_centre_resp", 0, resp);
        write_reg(8'h08, 32'(r2), resp);
        check_value("cfg_radius_resp", 0, resp);
        write_reg(8'h0c, {8'h0, obj}, resp);
        check_value("cfg_obj_resp", 0, resp);
        write_reg(8'h10, {8'h0, bg}, resp);
        check_value("cfg_bg_resp", 0, resp);
    endtask

    task automatic wait_frame_beat(input int frame, input int beat);
        while (frames_done < frame || (frames_done == frame && beat_idx < beat)) begin
            @(negedge out_stream_aclk);
        end
    endtask

    // clear enable while the frame runs, then watch the stream stay quiet
    task automatic stop_mid_frame(input int frame);
        logic [1:0] resp;
        wait_frame_beat(frame, 24);
        write_reg(8'h00, 32'h0, resp);
        check_value("disable_resp", 0, resp);
        wait_frame_beat(frame + 1, 0);
        stopped = 1'b1;
        repeat (100) @(negedge out_stream_aclk);
        stopped = 1'b0;
    endtask

    always @(negedge out_stream_aclk) begin
        if (random_ready) begin
            lfsr_state = lfsr_step(lfsr_state);
            tready     = lfsr_state[0];
        end else begin
            tready = 1'b1;
        end
    end

    always @(posedge out_stream_aclk) begin
        if (axi_resetn && tvalid && tready) begin
            check_value("shade_data", expected_word(beat_idx), tdata);
            check_value("stream_tkeep", 32'hf, 32'(tkeep));
            check_value("frame_tuser", 32'(beat_idx == 0), 32'(tuser));
            check_value("frame_tlast", 32'(beat_idx % BEATS_PER_LINE == BEATS_PER_LINE - 1),
                        32'(tlast));
            if (frames_done == 0) begin
                first_frame[beat_idx] = tdata;
            end else if (frames_done <= 3) begin
                check_value("backpressure", first_frame[beat_idx], tdata);
            end
            if (beat_idx == FRAME_BEATS - 1) begin
                beat_idx = 0;
                frames_done++;
            end else begin
                beat_idx++;
            end
        end
        if (stopped && tvalid) begin
            errors++;
            $display("tvalid came up again after enable was cleared");
        end
    end

    always @(posedge out_stream_aclk) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: the stream stalled, run not finished after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        logic [1:0]  resp;
        logic [31:0] data;
        out_stream_aclk = 1'b0;
        axi_resetn      = 1'b0;
        araddr          = '0;
        arvalid         = 1'b0;
        awaddr          = '0;
        awvalid         = 1'b0;
        bready          = 1'b0;
        rready          = 1'b0;
        wdata           = '0;
        wvalid          = 1'b0;
        tready          = 1'b1;
        random_ready    = 1'b0;
        stopped         = 1'b0;
        lfsr_state      = 32'he3bf_f2ae;
        errors          = 0;
        checks          = 0;
        cycles          = 0;
        beat_idx        = 0;
        frames_done     = 0;
        repeat (8) @(negedge out_stream_aclk);
        axi_resetn = 1'b1;

        @(negedge out_stream_aclk);
        check_value("reset_tvalid", 0, 32'(tvalid));
        check_value("reset_bvalid", 0, 32'(bvalid));
        check_value("reset_rvalid", 0, 32'(rvalid));
        check_value("reset_awready", 1, 32'(awready));
        check_value("reset_wready", 1, 32'(wready));
        check_value("reset_arready", 1, 32'(arready));

        for (int i = 0; i < 5; i++) begin
            write_reg(8'(i * 4), REG_VALS[i], resp);
            check_value("reg_write_resp", 0, resp);
        end
        for (int i = 0; i < 5; i++) begin
            read_reg(8'(i * 4), data, resp);
            check_value("reg_read_resp", 0, resp);
            check_value("reg_read_data", REG_VALS[i], data);
        end
        for (int i = 5; i < 8; i++) begin // unmapped words
            write_reg(8'(i * 4), 32'hffff_ffff, resp);
            check_value("bad_write_resp", 2, resp);
            read_reg(8'(i * 4), data, resp);
            check_value("bad_read_resp", 2, resp);
            check_value("bad_read_data", 0, data);
        end

        configure_disc(8, 4, 60, 24'hf0_80_05, 24'h10_20_30);
        write_reg(8'h00, 32'h1, resp);
        wait_frame_beat(1, 0);
        random_ready = 1'b1;
        stop_mid_frame(3);

        configure_disc(3, 5, 30, 24'h08_ff_40, 24'h00_00_ff);
        write_reg(8'h00, 32'h1, resp);
        stop_mid_frame(4);
        check_value("frame_count", NUM_FRAMES, frames_done);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
rtl/pg_pkg.sv
rtl/pg_regfile.sv
rtl/pixel_scan.sv
rtl/shade_lane.sv
rtl/pixel_packer.sv
rtl/pixel_generator.sv
bench/pixel_generator_props.sv
bench/tb_pixel_generator.sv

//--- rtl/pg_macros.svh
`ifndef PG_MACROS_SVH
`define PG_MACROS_SVH

// frame geometry in pixels
`define PG_WIDTH 16
`define PG_HEIGHT 8

// pixels per group, four 24-bit pixels fill three 32-bit beats
`define PG_LANES 4

// squared distance is shifted right by this before darkening
`define PG_FALLOFF_SHIFT 2

// groups held in the packer, also the credit count
`define PG_FIFO_DEPTH 4

// implemented config registers
`define PG_NUM_REGS 5

`endif

//--- rtl/pg_pkg.sv
`default_nettype none

package pg_pkg;

    typedef logic [7:0]  coord_t;    // pixel x or y
    typedef logic [23:0] rgb_t;      // r 23:16, g 15:8, b 7:0
    typedef logic [16:0] dist_t;     // squared distance
    typedef logic [2:0]  reg_addr_t; // word index, addr 4:2

    typedef struct packed {
        logic   enable;
        coord_t center_x;
        coord_t center_y;
        dist_t  radius2;
        rgb_t   obj_color;
        rgb_t   bg_color;
    } pg_config_t;

    typedef struct packed {
        coord_t x0;  // x of first pixel in group
        coord_t y;
        logic   sof;
        logic   eol;
    } pixel_group_t;

    typedef struct packed {
        rgb_t color;
        logic sof;
        logic eol;
    } lane_out_t;

    typedef enum logic [2:0] {
        wr_idle,
        wr_have_addr,
        wr_have_data,
        wr_commit,
        wr_resp
    } wr_state_e;

    typedef enum logic [1:0] {
        rd_idle,
        rd_fetch,
        rd_data
    } rd_state_e;

endpackage

`default_nettype wire

//--- rtl/pg_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "pg_macros.svh"

module pg_regfile (
    input  wire                 out_stream_aclk,
    input  wire                 axi_resetn,

    input  wire  [7:0]          s_axi_lite_awaddr,
    input  wire                 s_axi_lite_awvalid,
    output logic                s_axi_lite_awready,
    input  wire  [31:0]         s_axi_lite_wdata,
    input  wire                 s_axi_lite_wvalid,
    output logic                s_axi_lite_wready,
    output logic [1:0]          s_axi_lite_bresp,
    output logic                s_axi_lite_bvalid,
    input  wire                 s_axi_lite_bready,

    input  wire  [7:0]          s_axi_lite_araddr,
    input  wire                 s_axi_lite_arvalid,
    output logic                s_axi_lite_arready,
    output logic [31:0]         s_axi_lite_rdata,
    output logic [1:0]          s_axi_lite_rresp,
    output logic                s_axi_lite_rvalid,
    input  wire                 s_axi_lite_rready,

    output pg_pkg::pg_config_t  cfg
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    pg_pkg::wr_state_e wr_state;
    pg_pkg::rd_state_e rd_state;
    pg_pkg::reg_addr_t wr_addr;
    pg_pkg::reg_addr_t rd_addr;
    logic [31:0]       wr_data;
    logic [31:0]       regs [`PG_NUM_REGS];
    logic              wr_addr_ok;
    logic              rd_addr_ok;

    assign wr_addr_ok = (wr_addr < pg_pkg::reg_addr_t'(`PG_NUM_REGS));
    assign rd_addr_ok = (rd_addr < pg_pkg::reg_addr_t'(`PG_NUM_REGS));

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            wr_state <= pg_pkg::wr_idle;
            for (int i = 0; i < `PG_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            case (wr_state)
                pg_pkg::wr_idle: begin
                    if (s_axi_lite_awvalid) wr_addr <= s_axi_lite_awaddr[4:2];
                    if (s_axi_lite_wvalid) wr_data <= s_axi_lite_wdata;
                    if (s_axi_lite_awvalid && s_axi_lite_wvalid) begin
                        wr_state <= pg_pkg::wr_commit;
                    end else if (s_axi_lite_awvalid) begin
                        wr_state <= pg_pkg::wr_have_addr;
                    end else if (s_axi_lite_wvalid) begin
                        wr_state <= pg_pkg::wr_have_data;
                    end
                end
                pg_pkg::wr_have_addr: begin // waiting for data
                    if (s_axi_lite_wvalid) begin
                        wr_data  <= s_axi_lite_wdata;
                        wr_state <= pg_pkg::wr_commit;
                    end
                end
                pg_pkg::wr_have_data: begin // waiting for address
                    if (s_axi_lite_awvalid) begin
                        wr_addr  <= s_axi_lite_awaddr[4:2];
                        wr_state <= pg_pkg::wr_commit;
                    end
                end
                pg_pkg::wr_commit: begin
                    if (wr_addr_ok) regs[wr_addr] <= wr_data; // bad index dropped
                    wr_state <= pg_pkg::wr_resp;
                end
                pg_pkg::wr_resp: begin
                    if (s_axi_lite_bready) wr_state <= pg_pkg::wr_idle;
                end
                default: wr_state <= pg_pkg::wr_idle;
            endcase
        end
    end

    assign s_axi_lite_awready = (wr_state == pg_pkg::wr_idle) ||
                                (wr_state == pg_pkg::wr_have_data);
    assign s_axi_lite_wready  = (wr_state == pg_pkg::wr_idle) ||
                                (wr_state == pg_pkg::wr_have_addr);
    assign s_axi_lite_bvalid  = (wr_state == pg_pkg::wr_resp);
    assign s_axi_lite_bresp   = wr_addr_ok ? RESP_OKAY : RESP_SLVERR;

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            rd_state <= pg_pkg::rd_idle;
        end else begin
            case (rd_state)
                pg_pkg::rd_idle: begin
                    if (s_axi_lite_arvalid) begin
                        rd_addr  <= s_axi_lite_araddr[4:2];
                        rd_state <= pg_pkg::rd_fetch;
                    end
                end
                pg_pkg::rd_fetch: begin
                    s_axi_lite_rdata <= rd_addr_ok ? regs[rd_addr] : '0;
                    rd_state         <= pg_pkg::rd_data;
                end
                pg_pkg::rd_data: begin
                    if (s_axi_lite_rready) rd_state <= pg_pkg::rd_idle;
                end
                default: rd_state <= pg_pkg::rd_idle;
            endcase
        end
    end

    assign s_axi_lite_arready = (rd_state == pg_pkg::rd_idle);
    assign s_axi_lite_rvalid  = (rd_state == pg_pkg::rd_data);
    assign s_axi_lite_rresp   = rd_addr_ok ? RESP_OKAY : RESP_SLVERR;

    always_comb begin
        cfg.enable    = regs[0][0];
        cfg.center_x  = regs[1][7:0];
        cfg.center_y  = regs[1][15:8];
        cfg.radius2   = {1'b0, regs[2][15:0]};
        cfg.obj_color = regs[3][23:0];
        cfg.bg_color  = regs[4][23:0];
    end

endmodule

`default_nettype wire

//--- rtl/pixel_generator.sv
`timescale 1ns/10ps
`default_nettype none

`include "pg_macros.svh"

module pixel_generator (
    input  wire         out_stream_aclk,
    input  wire         axi_resetn,

    output logic [31:0] out_stream_tdata,
    output logic [3:0]  out_stream_tkeep,
    output logic        out_stream_tlast,
    input  wire         out_stream_tready,
    output logic        out_stream_tvalid,
    output logic        out_stream_tuser,

    input  wire  [7:0]  s_axi_lite_araddr,
    output logic        s_axi_lite_arready,
    input  wire         s_axi_lite_arvalid,
    input  wire  [7:0]  s_axi_lite_awaddr,
    output logic        s_axi_lite_awready,
    input  wire         s_axi_lite_awvalid,
    input  wire         s_axi_lite_bready,
    output logic [1:0]  s_axi_lite_bresp,
    output logic        s_axi_lite_bvalid,
    output logic [31:0] s_axi_lite_rdata,
    input  wire         s_axi_lite_rready,
    output logic [1:0]  s_axi_lite_rresp,
    output logic        s_axi_lite_rvalid,
    input  wire  [31:0] s_axi_lite_wdata,
    output logic        s_axi_lite_wready,
    input  wire         s_axi_lite_wvalid
);

    pg_pkg::pg_config_t                  cfg;
    pg_pkg::pixel_group_t                group;
    logic                                issue;
    logic                                has_credit;
    pg_pkg::lane_out_t [`PG_LANES-1:0]   lane_pixels;
    logic [`PG_LANES-1:0]                lane_valid;

    pg_regfile u_regfile (
        .out_stream_aclk    (out_stream_aclk),
        .axi_resetn         (axi_resetn),
        .s_axi_lite_awaddr  (s_axi_lite_awaddr),
        .s_axi_lite_awvalid (s_axi_lite_awvalid),
        .s_axi_lite_awready (s_axi_lite_awready),
        .s_axi_lite_wdata   (s_axi_lite_wdata),
        .s_axi_lite_wvalid  (s_axi_lite_wvalid),
        .s_axi_lite_wready  (s_axi_lite_wready),
        .s_axi_lite_bresp   (s_axi_lite_bresp),
        .s_axi_lite_bvalid  (s_axi_lite_bvalid),
        .s_axi_lite_bready  (s_axi_lite_bready),
        .s_axi_lite_araddr  (s_axi_lite_araddr),
        .s_axi_lite_arvalid (s_axi_lite_arvalid),
        .s_axi_lite_arready (s_axi_lite_arready),
        .s_axi_lite_rdata   (s_axi_lite_rdata),
        .s_axi_lite_rresp   (s_axi_lite_rresp),
        .s_axi_lite_rvalid  (s_axi_lite_rvalid),
        .s_axi_lite_rready  (s_axi_lite_rready),
        .cfg                (cfg)
    );

    pixel_scan u_scan (
        .out_stream_aclk (out_stream_aclk),
        .axi_resetn      (axi_resetn),
        .cfg             (cfg),
        .has_credit      (has_credit),
        .group           (group),
        .issue           (issue)
    );

    for (genvar i = 0; i < `PG_LANES; i++) begin : g_lane
        shade_lane u_lane (
            .out_stream_aclk (out_stream_aclk),
            .axi_resetn      (axi_resetn),
            .x               (group.x0 + pg_pkg::coord_t'(i)),
            .y               (group.y),
            .in_valid        (issue),
            .in_sof          (group.sof),
            .in_eol          (group.eol),
            .cfg             (cfg),
            .pixel           (lane_pixels[i]),
            .out_valid       (lane_valid[i])
        );
    end

    pixel_packer u_packer (
        .out_stream_aclk   (out_stream_aclk),
        .axi_resetn        (axi_resetn),
        .pixels            (lane_pixels),
        .in_valid          (&lane_valid), // lanes run in lockstep
        .issue             (issue),
        .has_credit        (has_credit),
        .out_stream_tdata  (out_stream_tdata),
        .out_stream_tkeep  (out_stream_tkeep),
        .out_stream_tlast  (out_stream_tlast),
        .out_stream_tuser  (out_stream_tuser),
        .out_stream_tvalid (out_stream_tvalid),
        .out_stream_tready (out_stream_tready)
    );

endmodule

`default_nettype wire

//--- rtl/pixel_packer.sv
`timescale 1ns/10ps
`default_nettype none

`include "pg_macros.svh"

module pixel_packer (
    input  wire                                   out_stream_aclk,
    input  wire                                   axi_resetn,
    input  wire pg_pkg::lane_out_t [`PG_LANES-1:0] pixels,
    input  wire                                   in_valid,
    input  wire                                   issue,
    output logic                                  has_credit,
    output logic [31:0]                           out_stream_tdata,
    output logic [3:0]                            out_stream_tkeep,
    output logic                                  out_stream_tlast,
    output logic                                  out_stream_tuser,
    output logic                                  out_stream_tvalid,
    input  wire                                   out_stream_tready
);

    localparam int DEPTH   = `PG_FIFO_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int CNT_W   = $clog2(DEPTH + 1);
    localparam int GROUP_W = `PG_LANES * 24;
    localparam int BEATS   = GROUP_W / 32;

    logic [GROUP_W-1:0] mem_data [DEPTH];
    logic               mem_sof  [DEPTH];
    logic               mem_eol  [DEPTH];
    logic [GROUP_W-1:0] in_word;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   credits;
    logic [1:0]         beat;
    logic               beat_fire;
    logic               pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_comb begin
        for (int i = 0; i < `PG_LANES; i++) begin
            in_word[i*24 +: 24] = pixels[i].color; // pixel 0 lowest
        end
    end

    assign beat_fire = out_stream_tvalid && out_stream_tready;
    assign pop       = beat_fire && (beat == 2'(BEATS - 1));

    // no full check, credits keep the fifo from overflowing
    always_ff @(posedge out_stream_aclk) begin
        if (in_valid) begin
            mem_data[wr_ptr] <= in_word;
            mem_sof[wr_ptr]  <= pixels[0].sof;
            mem_eol[wr_ptr]  <= pixels[0].eol;
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CNT_W'(DEPTH);
            beat    <= '0;
        end else begin
            if (in_valid) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            if (beat_fire) beat <= pop ? 2'd0 : beat + 2'd1;

            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            case ({issue, pop}) // credit back on third beat
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign has_credit        = (credits != '0);
    assign out_stream_tvalid = (count != '0);
    assign out_stream_tdata  = mem_data[rd_ptr][beat*32 +: 32];
    assign out_stream_tkeep  = 4'hf;
    assign out_stream_tuser  = (beat == 2'd0) && mem_sof[rd_ptr];
    assign out_stream_tlast  = (beat == 2'(BEATS - 1)) && mem_eol[rd_ptr];

endmodule

`default_nettype wire

//--- rtl/pixel_scan.sv
`timescale 1ns/10ps
`default_nettype none

`include "pg_macros.svh"

module pixel_scan (
    input  wire                  out_stream_aclk,
    input  wire                  axi_resetn,
    input  wire pg_pkg::pg_config_t cfg,
    input  wire                  has_credit,
    output pg_pkg::pixel_group_t group,
    output logic                 issue
);

    localparam pg_pkg::coord_t LAST_X0 = pg_pkg::coord_t'(`PG_WIDTH - `PG_LANES);
    localparam pg_pkg::coord_t LAST_Y  = pg_pkg::coord_t'(`PG_HEIGHT - 1);

    pg_pkg::coord_t x0;
    pg_pkg::coord_t y;
    logic           running; // mid-frame, ignores enable
    logic           last_x;
    logic           last_y;

    assign last_x = (x0 == LAST_X0);
    assign last_y = (y == LAST_Y);

    // new frames only start at the boundary with enable set
    assign issue = has_credit && (running || cfg.enable);

    always_comb begin
        group.x0  = x0;
        group.y   = y;
        group.sof = (x0 == '0) && (y == '0);
        group.eol = last_x;
    end

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            x0      <= '0;
            y       <= '0;
            running <= 1'b0;
        end else if (issue) begin
            if (last_x) begin
                x0 <= '0;
                y  <= last_y ? '0 : y + 1'b1;
            end else begin
                x0 <= x0 + pg_pkg::coord_t'(`PG_LANES);
            end
            running <= !(last_x && last_y);
        end
    end

endmodule

`default_nettype wire

//--- rtl/shade_lane.sv
`timescale 1ns/10ps
`default_nettype none

`include "pg_macros.svh"

module shade_lane (
    input  wire                      out_stream_aclk,
    input  wire                      axi_resetn,
    input  wire pg_pkg::coord_t      x,
    input  wire pg_pkg::coord_t      y,
    input  wire                      in_valid,
    input  wire                      in_sof,
    input  wire                      in_eol,
    input  wire pg_pkg::pg_config_t  cfg,
    output pg_pkg::lane_out_t        pixel,
    output logic                     out_valid
);

    logic signed [8:0]  dx;
    logic signed [8:0]  dy;
    logic signed [17:0] dx2;
    logic signed [17:0] dy2;
    pg_pkg::dist_t      dist_q;
    pg_pkg::dist_t      falloff;
    logic               valid_q;
    logic               sof_q;
    logic               eol_q;

    function automatic logic [7:0] sub_sat(input logic [7:0] c, input pg_pkg::dist_t d);
        if (d >= {9'd0, c}) return 8'd0;
        return c - d[7:0];
    endfunction

    assign dx  = $signed({1'b0, x}) - $signed({1'b0, cfg.center_x});
    assign dy  = $signed({1'b0, y}) - $signed({1'b0, cfg.center_y});
    assign dx2 = dx * dx;
    assign dy2 = dy * dy;

    assign falloff = dist_q >> `PG_FALLOFF_SHIFT;

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_q   <= in_valid;
            out_valid <= valid_q;
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        dist_q <= pg_pkg::dist_t'(dx2 + dy2); // max 130050, fits 17 bits
        sof_q  <= in_sof;
        eol_q  <= in_eol;

        if (dist_q < cfg.radius2) begin
            pixel.color <= {sub_sat(cfg.obj_color[23:16], falloff),
                            sub_sat(cfg.obj_color[15:8], falloff),
                            sub_sat(cfg.obj_color[7:0], falloff)};
        end else begin
            pixel.color <= cfg.bg_color;
        end
        pixel.sof <= sof_q;
        pixel.eol <= eol_q;
    end

endmodule

`default_nettype wire
